/* hw/core_pkg.sv */
package core_pkg;

   localparam int XLEN       = 32;   // Data and instruction width
   localparam int REG_COUNT  = 32;   // Architectural registers
   localparam int REG_ADDR_W = 5;    // Register index width

   typedef logic [XLEN-1:0]       word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;

   localparam word_t NOP_INSTR = 32'h0000_0013;   // ADDI x0,x0,0

   // Major opcodes that decode understands
   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,   // Register-register ALU
      OPC_OP_IMM = 7'b0010011,   // Register-immediate ALU
      OPC_LUI    = 7'b0110111,
      OPC_BRANCH = 7'b1100011
   } rv_opcode_e;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLL,
      ALU_SRL,
      ALU_PASS_B,   // LUI result
      ALU_BEQ,
      ALU_BNE
   } alu_op_e;

   // Combinational decode result, before the ID/EX register
   typedef struct packed {
      logic    supported;   // Clear for any encoding outside the subset
      alu_op_e alu_op;
      logic    writes_rd;
      logic    use_imm;     // Operand b from imm instead of rs2
      word_t   imm;         // I, U or B immediate
   } decoded_op_t;

endpackage

/* hw/pipeline_ifs.sv */
`timescale 1ns/10ps

// ID/EX register contents
interface decode_exec_if;
   logic                valid;
   core_pkg::word_t     pc;
   core_pkg::alu_op_e   alu_op;
   core_pkg::reg_addr_t rd;
   logic                writes_rd;
   core_pkg::word_t     operand_a;       // rs1
   core_pkg::word_t     operand_b;       // Immediate or rs2
   core_pkg::word_t     rs2_value;       // Branch compare
   core_pkg::word_t     branch_offset;

   modport decode (output valid, pc, alu_op, rd, writes_rd, operand_a, operand_b,
                   rs2_value, branch_offset);
   modport exec   (input  valid, pc, alu_op, rd, writes_rd, operand_a, operand_b,
                   rs2_value, branch_offset);
endinterface

// Two read ports on the register file, data back in the same cycle
interface reg_read_if;
   core_pkg::reg_addr_t rs1_addr;
   core_pkg::reg_addr_t rs2_addr;
   core_pkg::word_t     rs1_data;
   core_pkg::word_t     rs2_data;

   modport decode  (output rs1_addr, rs2_addr,
                    input  rs1_data, rs2_data);
   modport regfile (input  rs1_addr, rs2_addr,
                    output rs1_data, rs2_data);
endinterface

/* hw/program_memory.sv */
`timescale 1ns/10ps

module program_memory #(
   parameter int IMEM_DEPTH = 64
) (
   input  logic            clk,
   input  logic            write_enable,
   input  core_pkg::word_t write_address,   // Byte address
   input  core_pkg::word_t write_data,
   input  core_pkg::word_t read_address,    // Byte address
   output core_pkg::word_t read_data
);

   localparam int ADDR_W = $clog2(IMEM_DEPTH);

   core_pkg::word_t mem [IMEM_DEPTH];   // Instruction words, no reset

   always_ff @(posedge clk) begin
      if (write_enable) begin
         mem[write_address[ADDR_W+1:2]] <= write_data;   // Word index
      end
   end

   assign read_data = mem[read_address[ADDR_W+1:2]];   // Async read for fetch

   // Loader must hand in whole words
   a_write_aligned: assert property (@(posedge clk)
      write_enable |-> (write_address[1:0] == 2'b00))
      else $error("program_memory: unaligned write address %h", write_address);

endmodule

/* hw/fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage #(
   parameter int IMEM_DEPTH = 64
) (
   input  logic            clk,
   input  logic            rst,
   input  logic            hold,            // Program loading
   input  logic            branch_taken,
   input  core_pkg::word_t branch_target,
   output core_pkg::word_t fetch_addr,
   input  core_pkg::word_t fetch_data,
   output logic            if_valid,
   output core_pkg::word_t if_pc,
   output core_pkg::word_t if_instr
);

   localparam int                ADDR_W    = $clog2(IMEM_DEPTH);
   localparam logic [ADDR_W-1:0] LAST_WORD = ADDR_W'(IMEM_DEPTH - 1);

   core_pkg::word_t pc;
   logic            at_top;   // PC sits on the last memory word

   assign at_top     = (pc[ADDR_W+1:2] == LAST_WORD);
   assign fetch_addr = pc;

   ///////////////////////////////////////////////////////////////////////
   // PC
   always_ff @(posedge clk) begin
      if (rst || hold) begin
         pc <= '0;
      end else if (branch_taken) begin
         pc <= branch_target;             // Redirect from execute
      end else if (!at_top) begin
         pc <= pc + 32'd4;
      end                                 // At top keep fetching same word
   end

   ///////////////////////////////////////////////////////////////////////
   // IF/ID register
   always_ff @(posedge clk) begin
      if (rst || hold || branch_taken) begin
         if_valid <= 1'b0;
         if_pc    <= '0;
         if_instr <= core_pkg::NOP_INSTR;   // Squash younger fetch
      end else begin
         if_valid <= 1'b1;
         if_pc    <= pc;
         if_instr <= fetch_data;
      end
   end

   // Targets come from pc + B offset, so alignment must hold across redirects
   a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
      pc[1:0] == 2'b00)
      else $error("fetch_stage: misaligned pc %h", pc);

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
   input  logic            clk,
   input  logic            rst,
   input  logic            hold,
   input  logic            branch_taken,   // Squash, ID holds a younger instr
   input  logic            if_valid,
   input  core_pkg::word_t if_pc,
   input  core_pkg::word_t if_instr,
   reg_read_if.decode      rd_port,
   decode_exec_if.decode   to_exec
);

   core_pkg::rv_opcode_e  opcode;
   logic [2:0]            funct3;
   logic [6:0]            funct7;
   core_pkg::reg_addr_t   rd;
   core_pkg::word_t       imm_i;
   core_pkg::word_t       imm_u;
   core_pkg::word_t       imm_b;
   core_pkg::decoded_op_t dec;

   assign opcode = core_pkg::rv_opcode_e'(if_instr[6:0]);
   assign funct3 = if_instr[14:12];
   assign funct7 = if_instr[31:25];
   assign rd     = if_instr[11:7];

   assign rd_port.rs1_addr = if_instr[19:15];
   assign rd_port.rs2_addr = if_instr[24:20];

   // Immediate formats
   assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
   assign imm_u = {if_instr[31:12], 12'b0};
   assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
                   if_instr[11:8], 1'b0};

   always_comb begin
      dec        = '0;
      dec.alu_op = core_pkg::ALU_ADD;
      case (opcode)
         core_pkg::OPC_OP: begin
            dec.writes_rd = 1'b1;
            dec.supported = (funct7 == 7'h00) || (funct7 == 7'h20 && funct3 == 3'b000);
            case (funct3)
               3'b000:  dec.alu_op = funct7[5] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
               3'b001:  dec.alu_op = core_pkg::ALU_SLL;
               3'b010:  dec.alu_op = core_pkg::ALU_SLT;
               3'b100:  dec.alu_op = core_pkg::ALU_XOR;
               3'b101:  dec.alu_op = core_pkg::ALU_SRL;   // SRA falls out on funct7
               3'b110:  dec.alu_op = core_pkg::ALU_OR;
               3'b111:  dec.alu_op = core_pkg::ALU_AND;
               default: dec.supported = 1'b0;             // SLTU
            endcase
         end
         core_pkg::OPC_OP_IMM: begin
            dec.writes_rd = 1'b1;
            dec.use_imm   = 1'b1;
            dec.imm       = imm_i;
            dec.supported = 1'b1;
            case (funct3)
               3'b000:  dec.alu_op = core_pkg::ALU_ADD;
               3'b100:  dec.alu_op = core_pkg::ALU_XOR;
               3'b110:  dec.alu_op = core_pkg::ALU_OR;
               3'b111:  dec.alu_op = core_pkg::ALU_AND;
               default: dec.supported = 1'b0;   // Shifts and SLTI not in subset
            endcase
         end
         core_pkg::OPC_LUI: begin
            dec.supported = 1'b1;
            dec.writes_rd = 1'b1;
            dec.use_imm   = 1'b1;
            dec.imm       = imm_u;
            dec.alu_op    = core_pkg::ALU_PASS_B;
         end
         core_pkg::OPC_BRANCH: begin
            dec.imm       = imm_b;   // Offset only, compare uses rs2
            dec.supported = (funct3 == 3'b000) || (funct3 == 3'b001);
            dec.alu_op    = funct3[0] ? core_pkg::ALU_BNE : core_pkg::ALU_BEQ;
         end
         default: ;   // Bubble
      endcase
   end

   ///////////////////////////////////////////////////////////////////////
   // ID/EX register
   always_ff @(posedge clk) begin
      if (rst || hold || branch_taken) begin
         to_exec.valid     <= 1'b0;
         to_exec.writes_rd <= 1'b0;
         to_exec.alu_op    <= core_pkg::ALU_ADD;
      end else begin
         to_exec.valid     <= if_valid && dec.supported;
         to_exec.writes_rd <= dec.writes_rd;
         to_exec.alu_op    <= dec.alu_op;
      end
   end

   always_ff @(posedge clk) begin
      to_exec.pc            <= if_pc;
      to_exec.rd            <= rd;
      to_exec.operand_a     <= rd_port.rs1_data;
      to_exec.operand_b     <= dec.use_imm ? dec.imm : rd_port.rs2_data;
      to_exec.rs2_value     <= rd_port.rs2_data;
      to_exec.branch_offset <= dec.imm;
   end

endmodule

/* hw/register_file.sv */
`timescale 1ns/10ps

module register_file (
   input  logic                clk,
   input  logic                rst,
   reg_read_if.regfile         rd_port,
   input  logic                wb_en,
   input  core_pkg::reg_addr_t wb_rd,
   input  core_pkg::word_t     wb_data,
   output core_pkg::word_t     reg_debug [core_pkg::REG_COUNT]
);

   core_pkg::word_t regs [core_pkg::REG_COUNT];

   // Write-through lets a dependent instr one behind see the new value
   function automatic core_pkg::word_t read_reg(input core_pkg::reg_addr_t addr);
      if (addr == '0) begin
         return '0;                      // x0 hardwired
      end else if (wb_en && wb_rd == addr) begin
         return wb_data;                 // Bypass
      end else begin
         return regs[addr];
      end
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < core_pkg::REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_en && wb_rd != '0) begin
         regs[wb_rd] <= wb_data;
      end
   end

   assign rd_port.rs1_data = read_reg(rd_port.rs1_addr);
   assign rd_port.rs2_data = read_reg(rd_port.rs2_addr);

   assign reg_debug = regs;   // Debug view for the testbench

   // x0 storage keeps its reset value
   a_x0_zero: assert property (@(posedge clk) disable iff (rst)
      regs[0] == '0)
      else $error("register_file: x0 modified");

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
   input  logic                clk,
   input  logic                rst,
   decode_exec_if.exec         from_dec,
   output logic                wb_en,
   output core_pkg::reg_addr_t wb_rd,
   output core_pkg::word_t     wb_data,
   output logic                branch_taken,
   output core_pkg::word_t     branch_target
);

   core_pkg::word_t result;
   logic [4:0]      shamt;
   logic            less_than;       // Signed a < b
   logic            operands_equal;  // rs1 == rs2 for branches

   assign shamt          = from_dec.operand_b[4:0];
   assign less_than      = $signed(from_dec.operand_a) < $signed(from_dec.operand_b);
   assign operands_equal = (from_dec.operand_a == from_dec.rs2_value);

   ///////////////////////////////////////////////////////////////////////
   // ALU
   always_comb begin
      case (from_dec.alu_op)
         core_pkg::ALU_ADD:    result = from_dec.operand_a + from_dec.operand_b;
         core_pkg::ALU_SUB:    result = from_dec.operand_a - from_dec.operand_b;
         core_pkg::ALU_AND:    result = from_dec.operand_a & from_dec.operand_b;
         core_pkg::ALU_OR:     result = from_dec.operand_a | from_dec.operand_b;
         core_pkg::ALU_XOR:    result = from_dec.operand_a ^ from_dec.operand_b;
         core_pkg::ALU_SLT:    result = {{(core_pkg::XLEN-1){1'b0}}, less_than};
         core_pkg::ALU_SLL:    result = from_dec.operand_a << shamt;
         core_pkg::ALU_SRL:    result = from_dec.operand_a >> shamt;   // Logical
         core_pkg::ALU_PASS_B: result = from_dec.operand_b;            // LUI
         default:              result = '0;                            // Branches
      endcase
   end

   ///////////////////////////////////////////////////////////////////////
   // Writeback, lands in the register file at the next edge
   assign wb_en   = from_dec.valid && from_dec.writes_rd && (from_dec.rd != '0);
   assign wb_rd   = from_dec.rd;
   assign wb_data = result;

   ///////////////////////////////////////////////////////////////////////
   // Branch resolution
   always_comb begin
      branch_taken = 1'b0;
      if (from_dec.valid) begin
         case (from_dec.alu_op)
            core_pkg::ALU_BEQ: branch_taken = operands_equal;
            core_pkg::ALU_BNE: branch_taken = !operands_equal;
            default:           branch_taken = 1'b0;
         endcase
      end
   end

   assign branch_target = from_dec.pc + from_dec.branch_offset;

   // Taken branch flushes ID/EX, so the next cycle holds a bubble
   a_branch_pulse: assert property (@(posedge clk) disable iff (rst)
      branch_taken |-> from_dec.valid ##1 !from_dec.valid)
      else $error("execute_stage: branch_taken without a single-cycle valid branch");

endmodule

/* hw/core_top.sv */
`timescale 1ns/10ps

module core_top #(
   parameter int IMEM_DEPTH = 64
) (
   input  logic            clk,
   input  logic            rst,
   input  logic            imem_en,        // Loading, holds the pipeline
   input  core_pkg::word_t write_address,
   input  core_pkg::word_t imem_data_in,
   output core_pkg::word_t reg_debug [core_pkg::REG_COUNT],
   output logic            branch_taken
);

   core_pkg::word_t     fetch_addr;
   core_pkg::word_t     fetch_data;
   logic                if_valid;
   core_pkg::word_t     if_pc;
   core_pkg::word_t     if_instr;
   core_pkg::word_t     branch_target;
   logic                wb_en;
   core_pkg::reg_addr_t wb_rd;
   core_pkg::word_t     wb_data;

   decode_exec_if id_ex_bus ();
   reg_read_if    rf_read_bus ();

   ///////////////////////////////////////////////////////////////////////
   // Fetch
   program_memory #(.IMEM_DEPTH(IMEM_DEPTH)) imem_i (
      .clk           (clk),
      .write_enable  (imem_en),
      .write_address (write_address),
      .write_data    (imem_data_in),
      .read_address  (fetch_addr),
      .read_data     (fetch_data)
   );

   fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) fetch_i (
      .clk           (clk),
      .rst           (rst),
      .hold          (imem_en),
      .branch_taken  (branch_taken),
      .branch_target (branch_target),
      .fetch_addr    (fetch_addr),
      .fetch_data    (fetch_data),
      .if_valid      (if_valid),
      .if_pc         (if_pc),
      .if_instr      (if_instr)
   );

   ///////////////////////////////////////////////////////////////////////
   // Decode and register read
   decode_stage decode_i (
      .clk          (clk),
      .rst          (rst),
      .hold         (imem_en),
      .branch_taken (branch_taken),
      .if_valid     (if_valid),
      .if_pc        (if_pc),
      .if_instr     (if_instr),
      .rd_port      (rf_read_bus.decode),
      .to_exec      (id_ex_bus.decode)
   );

   register_file regfile_i (
      .clk       (clk),
      .rst       (rst),
      .rd_port   (rf_read_bus.regfile),
      .wb_en     (wb_en),
      .wb_rd     (wb_rd),
      .wb_data   (wb_data),
      .reg_debug (reg_debug)
   );

   ///////////////////////////////////////////////////////////////////////
   // Execute
   execute_stage execute_i (
      .clk           (clk),
      .rst           (rst),
      .from_dec      (id_ex_bus.exec),
      .wb_en         (wb_en),
      .wb_rd         (wb_rd),
      .wb_data       (wb_data),
      .branch_taken  (branch_taken),
      .branch_target (branch_target)
   );

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
   parameter int PERIOD_NS    = 20,
   parameter int RESET_CYCLES = 3
) (
   output logic clk,
   output logic rst,
   input  logic reset_req   // One-cycle request for a fresh reset
);

   int unsigned cycles_left = RESET_CYCLES;   // Reset cycles still to go, start in reset

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      if (reset_req) begin
         cycles_left <= RESET_CYCLES;       // Restart the reset window
      end else if (cycles_left != 0) begin
         cycles_left <= cycles_left - 1;
      end
   end

   assign rst = (cycles_left != 0);

endmodule

/* sim/tb_checker.sv */
`timescale 1ns/10ps

module tb_checker (
   input logic            clk,
   input logic            rst,
   input logic            imem_en,
   input core_pkg::word_t reg_debug [core_pkg::REG_COUNT],
   input logic            branch_taken
);

   int run_pulses;            // Taken branches while the program runs
   int load_pulses;           // Taken branches while loading, must stay 0
   int test_errors  = 0;      // Failed checks in the current test
   int tests_passed = 0;
   int tests_failed = 0;

   always @(posedge clk) begin
      if (rst) begin
         run_pulses  <= 0;
         load_pulses <= 0;
      end else if (branch_taken) begin
         if (imem_en) begin
            load_pulses <= load_pulses + 1;
         end else begin
            run_pulses <= run_pulses + 1;
         end
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Called by the testbench top at a falling edge
   task automatic check_cleared(input string name);
      for (int i = 0; i < core_pkg::REG_COUNT; i++) begin
         if (reg_debug[i] !== '0) begin
            $display("error %s: x%0d after reset expected %h actual %h",
                     name, i, 32'h0, reg_debug[i]);
            test_errors++;
         end
      end
   endtask

   task automatic finish_test(input string name, input int reg_idx,
                              input core_pkg::word_t expected, input int pulses);
      if (reg_debug[reg_idx] !== expected) begin
         $display("error %s: x%0d expected %h actual %h",
                  name, reg_idx, expected, reg_debug[reg_idx]);
         test_errors++;
      end
      if (run_pulses != pulses) begin
         $display("error %s: branch pulses expected %0d actual %0d", name, pulses, run_pulses);
         test_errors++;
      end
      if (load_pulses != 0) begin
         $display("%s: branch_taken went high %0d times while the program was loading",
                  name, load_pulses);
         test_errors++;
      end
      if (test_errors == 0) begin
         tests_passed++;
         $display("test %s passed", name);
      end else begin
         tests_failed++;
         $display("test %s failed", name);
      end
      test_errors = 0;
   endtask

endmodule

/* sim/tb_core.sv */
`timescale 1ns/10ps

module tb_core;

   localparam int IMEM_DEPTH = 64;
   localparam int PROG_WORDS = 16;
   localparam int MAX_ROWS   = 24;
   localparam int RUN_CYCLES = IMEM_DEPTH * 4;
   localparam int ROW_BUDGET = IMEM_DEPTH * 6 + 10;   // Watchdog cycles per row
   localparam int LOOP_K     = 5;                     // Countdown iterations

   logic            clk;
   logic            rst;
   logic            reset_req;
   logic            imem_en;
   core_pkg::word_t write_address;
   core_pkg::word_t imem_data_in;
   core_pkg::word_t reg_debug [core_pkg::REG_COUNT];
   logic            branch_taken;

   ///////////////////////////////////////////////////////////////////////
   // Test table
   string           row_name   [MAX_ROWS];
   core_pkg::word_t row_prog   [MAX_ROWS][PROG_WORDS];
   int              row_len    [MAX_ROWS];
   int              row_reg    [MAX_ROWS];     // Checked register
   core_pkg::word_t row_expect [MAX_ROWS];
   int              row_pulses [MAX_ROWS];     // Expected taken branches
   int              row_count   = 0;
   logic            table_ready = 1'b0;
   core_pkg::word_t prog_q [$];                // Program of the row being built

   tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(3)) clock_i (
      .clk       (clk),
      .rst       (rst),
      .reset_req (reset_req)
   );

   core_top #(.IMEM_DEPTH(IMEM_DEPTH)) dut_i (
      .clk           (clk),
      .rst           (rst),
      .imem_en       (imem_en),
      .write_address (write_address),
      .imem_data_in  (imem_data_in),
      .reg_debug     (reg_debug),
      .branch_taken  (branch_taken)
   );

   tb_checker checker_i (
      .clk          (clk),
      .rst          (rst),
      .imem_en      (imem_en),
      .reg_debug    (reg_debug),
      .branch_taken (branch_taken)
   );

   ///////////////////////////////////////////////////////////////////////
   // RV32I encoders and result rules
   function automatic core_pkg::word_t i_type(input logic [11:0] imm,
         input core_pkg::reg_addr_t rs1, input logic [2:0] funct3,
         input core_pkg::reg_addr_t rd);
      return {imm, rs1, funct3, rd, 7'b0010011};
   endfunction

   function automatic core_pkg::word_t r_type(input logic [6:0] funct7,
         input core_pkg::reg_addr_t rs2, input core_pkg::reg_addr_t rs1,
         input logic [2:0] funct3, input core_pkg::reg_addr_t rd);
      return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
   endfunction

   function automatic core_pkg::word_t u_type(input logic [19:0] imm,
         input core_pkg::reg_addr_t rd);
      return {imm, rd, 7'b0110111};
   endfunction

   function automatic core_pkg::word_t b_type(input logic [12:0] offset,
         input core_pkg::reg_addr_t rs2, input core_pkg::reg_addr_t rs1,
         input logic [2:0] funct3);
      return {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11],
              7'b1100011};
   endfunction

   function automatic core_pkg::word_t sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   // Result by funct3 where alt selects SUB
   function automatic core_pkg::word_t rv_expect(input logic [2:0] funct3, input logic alt,
         input core_pkg::word_t a, input core_pkg::word_t b);
      case (funct3)
         3'b000:  return alt ? a - b : a + b;
         3'b001:  return a << b[4:0];
         3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'b100:  return a ^ b;
         3'b101:  return a >> b[4:0];
         3'b110:  return a | b;
         default: return a & b;
      endcase
   endfunction

   ///////////////////////////////////////////////////////////////////////
   // Table building
   task automatic add_row(input string name, input int reg_idx,
                          input core_pkg::word_t expected, input int pulses);
      row_name[row_count]   = name;
      row_len[row_count]    = prog_q.size();
      row_reg[row_count]    = reg_idx;
      row_expect[row_count] = expected;
      row_pulses[row_count] = pulses;
      for (int i = 0; i < prog_q.size(); i++) begin
         row_prog[row_count][i] = prog_q[i];
      end
      row_count++;
      prog_q.delete();
   endtask

   // x1 = a then x3 = x1 op b with b from an immediate or from x2
   task automatic alu_row(input string name, input logic [2:0] funct3, input logic alt,
                          input logic imm_form);
      logic [11:0] imm_a;
      logic [11:0] imm_b;
      imm_a = 12'($urandom);
      imm_b = 12'($urandom);
      prog_q.push_back(i_type(imm_a, 5'd0, 3'b000, 5'd1));
      if (imm_form) begin
         prog_q.push_back(i_type(imm_b, 5'd1, funct3, 5'd3));
      end else begin
         prog_q.push_back(i_type(imm_b, 5'd0, 3'b000, 5'd2));
         prog_q.push_back(r_type({1'b0, alt, 5'd0}, 5'd2, 5'd1, funct3, 5'd3));
      end
      add_row(name, 3, rv_expect(funct3, alt, sext12(imm_a), sext12(imm_b)), 0);
   endtask

   // x1 counts down from LOOP_K while x2 sums the counter values
   task automatic countdown_program();
      prog_q.push_back(i_type(12'(LOOP_K), 5'd0, 3'b000, 5'd1));
      prog_q.push_back(i_type(12'd0, 5'd0, 3'b000, 5'd2));
      prog_q.push_back(r_type(7'h00, 5'd1, 5'd2, 3'b000, 5'd2));   // Loop head
      prog_q.push_back(i_type(12'hfff, 5'd1, 3'b000, 5'd1));       // Minus one
      prog_q.push_back(b_type(13'h1ff8, 5'd0, 5'd1, 3'b001));      // Back to head
   endtask

   task automatic build_table();
      logic [19:0]     lui_imm;
      logic [11:0]     chain_imm;
      core_pkg::word_t chain_sum;
      prog_q.delete();                           // Empty program of all NOPs
      add_row("idle", 31, 32'h0, 0);
      alu_row("add", 3'b000, 1'b0, 1'b0);
      alu_row("sub", 3'b000, 1'b1, 1'b0);
      alu_row("and", 3'b111, 1'b0, 1'b0);
      alu_row("or", 3'b110, 1'b0, 1'b0);
      alu_row("xor", 3'b100, 1'b0, 1'b0);
      alu_row("slt", 3'b010, 1'b0, 1'b0);
      alu_row("sll", 3'b001, 1'b0, 1'b0);
      alu_row("srl", 3'b101, 1'b0, 1'b0);
      alu_row("addi", 3'b000, 1'b0, 1'b1);
      alu_row("andi", 3'b111, 1'b0, 1'b1);
      alu_row("ori", 3'b110, 1'b0, 1'b1);
      alu_row("xori", 3'b100, 1'b0, 1'b1);
      lui_imm = 20'($urandom);
      prog_q.push_back(u_type(lui_imm, 5'd4));
      add_row("lui", 4, {lui_imm, 12'h000}, 0);
      // Each ADDI reads the one before it through the bypass
      chain_sum = '0;
      for (int i = 0; i < 3; i++) begin
         chain_imm = 12'($urandom);
         chain_sum = chain_sum + sext12(chain_imm);
         prog_q.push_back(i_type(chain_imm, (i == 0) ? 5'd0 : 5'd5, 3'b000, 5'd5));
      end
      add_row("addi_chain", 5, chain_sum, 0);
      prog_q.push_back(i_type(12'd5, 5'd0, 3'b000, 5'd1));
      prog_q.push_back(i_type(12'd5, 5'd0, 3'b000, 5'd2));
      prog_q.push_back(b_type(13'd12, 5'd2, 5'd1, 3'b000));      // BEQ to word 5
      prog_q.push_back(i_type(12'd1, 5'd0, 3'b000, 5'd3));       // Squashed
      prog_q.push_back(i_type(12'd2, 5'd0, 3'b000, 5'd3));       // Squashed
      prog_q.push_back(i_type(12'd7, 5'd3, 3'b000, 5'd4));       // x4 = x3 + 7
      add_row("beq_taken", 4, 32'd7, 1);
      prog_q.push_back(i_type(12'd5, 5'd0, 3'b000, 5'd1));
      prog_q.push_back(i_type(12'd5, 5'd0, 3'b000, 5'd2));
      prog_q.push_back(b_type(13'd12, 5'd2, 5'd1, 3'b001));      // BNE falls through
      prog_q.push_back(i_type(12'd1, 5'd0, 3'b000, 5'd3));
      prog_q.push_back(i_type(12'd2, 5'd3, 3'b000, 5'd3));
      add_row("bne_fall", 3, 32'd3, 0);
      countdown_program();
      add_row("loop_counter", 1, 32'h0, LOOP_K - 1);
      countdown_program();
      add_row("loop_sum", 2, 32'(LOOP_K * (LOOP_K + 1) / 2), LOOP_K - 1);
      prog_q.push_back(i_type(12'd55, 5'd0, 3'b000, 5'd0));      // Write to x0
      prog_q.push_back(i_type(12'd3, 5'd0, 3'b000, 5'd1));       // Must read x0 as 0
      add_row("x0_write", 1, 32'd3, 0);
      prog_q.push_back(i_type(12'd55, 5'd0, 3'b000, 5'd0));      // Write to x0
      add_row("x0_stays_zero", 0, 32'h0, 0);
      prog_q.push_back(i_type(12'd9, 5'd0, 3'b000, 5'd7));
      prog_q.push_back(r_type(7'h00, 5'd0, 5'd7, 3'b011, 5'd7));              // SLTU
      prog_q.push_back(i_type(12'd1, 5'd7, 3'b001, 5'd7));                    // SLLI
      prog_q.push_back(i_type({7'h20, 5'd1}, 5'd7, 3'b101, 5'd7));            // SRAI
      prog_q.push_back(i_type(12'd100, 5'd7, 3'b010, 5'd7));                  // SLTI
      prog_q.push_back({12'd4, 5'd0, 3'b010, 5'd7, 7'b0000011});              // LW
      add_row("unsupported", 7, 32'd9, 0);
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Per-row sequence
   task automatic reset_core();
      @(posedge clk);
      reset_req <= 1'b1;
      imem_en   <= 1'b1;   // Old program stays frozen through reset
      @(posedge clk);
      reset_req <= 1'b0;
      @(posedge clk);
      while (rst) begin
         @(posedge clk);
      end
   endtask

   task automatic load_program(input int r);
      @(posedge clk);
      imem_en <= 1'b1;
      for (int a = 0; a < IMEM_DEPTH; a++) begin
         write_address <= core_pkg::word_t'(a * 4);
         if (a < row_len[r]) begin
            imem_data_in <= row_prog[r][a];
         end else begin
            imem_data_in <= core_pkg::NOP_INSTR;   // Fill including the last word
         end
         @(posedge clk);
      end
      imem_en <= 1'b0;
   endtask

   initial begin
      reset_req     = 1'b0;
      imem_en       = 1'b0;
      write_address = '0;
      imem_data_in  = core_pkg::NOP_INSTR;
      void'($urandom(37));
      build_table();
      table_ready = 1'b1;
      for (int r = 0; r < row_count; r++) begin
         reset_core();
         @(negedge clk);
         checker_i.check_cleared(row_name[r]);
         load_program(r);
         repeat (RUN_CYCLES) @(posedge clk);
         @(negedge clk);
         checker_i.finish_test(row_name[r], row_reg[r], row_expect[r], row_pulses[r]);
      end
      $display("%0d tests: %0d passed, %0d failed",
               row_count, checker_i.tests_passed, checker_i.tests_failed);
      if (checker_i.tests_failed == 0 && checker_i.tests_passed == row_count) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   // Watchdog budget scales with the table
   initial begin
      wait (table_ready);
      repeat (row_count * ROW_BUDGET) @(posedge clk);
      $display("watchdog: run still going after %0d cycles", row_count * ROW_BUDGET);
      $display("** FAIL **");
      $finish;
   end

endmodule

/* verilog.f */
hw/core_pkg.sv
hw/pipeline_ifs.sv
hw/program_memory.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/register_file.sv
hw/execute_stage.sv
hw/core_top.sv
sim/tb_clock.sv
sim/tb_checker.sv
sim/tb_core.sv

/* Makefile */
VERILATOR  = verilator
TOP        = tb_core
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
PASS_TEXT  = ** PASS **

.PHONY: run build lint clean

# Build, run, and decide the result from the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
